/* vlog.f */
hw/frontend_pkg.sv
hw/fetch_unit.sv
hw/inst_queue.sv
hw/decode_stage.sv
hw/frontend_top.sv
tb/frontend_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module frontend_tb -o frontend_sim
./obj_dir/frontend_sim | tee sim.log

if grep -qx '\*\* PASS \*\*' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

/* tb/frontend_tb.sv */
`timescale 1ns/10ps

module frontend_tb;

    localparam int TOTAL_INSTS = 2000;
    localparam int CYCLE_LIMIT = TOTAL_INSTS * 12;

    logic                    clk;
    logic                    rst;
    logic                    line_req_o;
    frontend_pkg::addr_t     line_addr_o;
    logic                    line_resp_i;
    frontend_pkg::line_t     line_data_i;
    logic                    redirect_i;
    frontend_pkg::addr_t     redirect_pc_i;
    logic                    stall_i;
    frontend_pkg::dec_inst_t dec_o;

    logic [31:0] mem [256];
    integer      seed;
    int          cycles;
    int          errors;
    int          checks;
    int          test_errors;
    int          accepted;
    int          pending_redirects;

    // line responder
    logic                resp_busy;
    logic                resp_stale;
    int                  resp_wait;
    frontend_pkg::addr_t resp_addr;

    // reference model
    frontend_pkg::addr_t     exp_pc;
    logic [63:0]             last_order;
    logic                    have_last;
    logic                    after_redirect;
    logic                    held_valid;
    frontend_pkg::dec_inst_t held;

    logic stall_en;
    int   redirect_rate;
    logic redirect_on_req;

    frontend_top uut (
        .clk           (clk),
        .rst           (rst),
        .line_req_o    (line_req_o),
        .line_addr_o   (line_addr_o),
        .line_resp_i   (line_resp_i),
        .line_data_i   (line_data_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .stall_i       (stall_i),
        .dec_o         (dec_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int rand_below(int n);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return r % n;
    endfunction

    task automatic fill_memory();
        logic [6:0]  opcodes [9];
        logic [31:0] w;
        opcodes = '{frontend_pkg::OPC_LUI, frontend_pkg::OPC_AUIPC, frontend_pkg::OPC_JAL,
                    frontend_pkg::OPC_JALR, frontend_pkg::OPC_BRANCH, frontend_pkg::OPC_LOAD,
                    frontend_pkg::OPC_STORE, frontend_pkg::OPC_OP_IMM, frontend_pkg::OPC_OP};
        for (int i = 0; i < 256; i++) begin
            w = $random(seed);
            // most words get a real opcode so every class shows up
            if (rand_below(4) != 0) begin
                w[6:0] = opcodes[rand_below(9)];
            end
            mem[i] = w;
        end
    endtask

    function automatic frontend_pkg::line_t line_at(frontend_pkg::addr_t a);
        frontend_pkg::line_t l;
        for (int i = 0; i < frontend_pkg::LINE_WORDS; i++) begin
            l[i] = mem[{a[9:5], 3'(i)}];
        end
        return l;
    endfunction

    // expected decode straight from the rv32i field layout
    function automatic frontend_pkg::dec_inst_t decode_model(frontend_pkg::inst_word_t w);
        frontend_pkg::dec_inst_t d;
        logic [6:0]              opc;
        logic                    uses_rd;
        logic                    uses_imm;
        d   = '0;
        opc = w.raw[6:0];
        if (opc inside {frontend_pkg::OPC_LUI, frontend_pkg::OPC_AUIPC,
                        frontend_pkg::OPC_OP_IMM, frontend_pkg::OPC_OP}) begin
            d.op_class = frontend_pkg::op_alu;
        end else if (opc inside {frontend_pkg::OPC_BRANCH, frontend_pkg::OPC_JAL,
                                 frontend_pkg::OPC_JALR}) begin
            d.op_class = frontend_pkg::op_br;
        end else if (opc inside {frontend_pkg::OPC_LOAD, frontend_pkg::OPC_STORE}) begin
            d.op_class = frontend_pkg::op_mem;
        end else begin
            d.op_class = frontend_pkg::op_none;
        end
        d.use_rs1 = opc inside {frontend_pkg::OPC_OP_IMM, frontend_pkg::OPC_OP,
                                frontend_pkg::OPC_BRANCH, frontend_pkg::OPC_JALR,
                                frontend_pkg::OPC_LOAD, frontend_pkg::OPC_STORE};
        d.use_rs2 = opc inside {frontend_pkg::OPC_OP, frontend_pkg::OPC_BRANCH,
                                frontend_pkg::OPC_STORE};
        uses_rd   = opc inside {frontend_pkg::OPC_LUI, frontend_pkg::OPC_AUIPC,
                                frontend_pkg::OPC_OP_IMM, frontend_pkg::OPC_OP,
                                frontend_pkg::OPC_JAL, frontend_pkg::OPC_JALR,
                                frontend_pkg::OPC_LOAD};
        uses_imm  = opc inside {frontend_pkg::OPC_OP_IMM, frontend_pkg::OPC_JALR,
                                frontend_pkg::OPC_LOAD};
        d.rd_addr  = uses_rd ? w.raw[11:7] : 5'd0;
        d.rs1_addr = d.use_rs1 ? w.raw[19:15] : 5'd0;
        d.rs2_addr = d.use_rs2 ? w.raw[24:20] : 5'd0;
        d.imm      = uses_imm ? {{20{w.raw[31]}}, w.raw[31:20]} : 32'd0;
        return d;
    endfunction

    task automatic note_mismatch(string name, logic [63:0] got, logic [63:0] exp);
        errors++;
        test_errors++;
        $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
    endtask

    task automatic fail_plain(string msg);
        errors++;
        test_errors++;
        $display("error: %s at %0t", msg, $time);
    endtask

    task automatic compare_pc(string name, frontend_pkg::addr_t got, frontend_pkg::addr_t exp);
        checks++;
        if (got !== exp) begin
            note_mismatch(name, 64'(got), 64'(exp));
        end
    endtask

    task automatic compare_inst(string name, frontend_pkg::inst_word_t got,
                                frontend_pkg::inst_word_t exp);
        checks++;
        if (got.raw !== exp.raw) begin
            note_mismatch(name, 64'(got.raw), 64'(exp.raw));
        end
    endtask

    task automatic compare_order(string name, logic [63:0] got, logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            note_mismatch(name, got, exp);
        end
    endtask

    task automatic compare_decode(frontend_pkg::dec_inst_t got, frontend_pkg::dec_inst_t exp);
        checks++;
        if (got.op_class !== exp.op_class) begin
            note_mismatch("dec_o.op_class", 64'(got.op_class), 64'(exp.op_class));
        end
        if (got.rd_addr !== exp.rd_addr) begin
            note_mismatch("dec_o.rd_addr", 64'(got.rd_addr), 64'(exp.rd_addr));
        end
        if (got.rs1_addr !== exp.rs1_addr) begin
            note_mismatch("dec_o.rs1_addr", 64'(got.rs1_addr), 64'(exp.rs1_addr));
        end
        if (got.rs2_addr !== exp.rs2_addr) begin
            note_mismatch("dec_o.rs2_addr", 64'(got.rs2_addr), 64'(exp.rs2_addr));
        end
        if (got.use_rs1 !== exp.use_rs1) begin
            note_mismatch("dec_o.use_rs1", 64'(got.use_rs1), 64'(exp.use_rs1));
        end
        if (got.use_rs2 !== exp.use_rs2) begin
            note_mismatch("dec_o.use_rs2", 64'(got.use_rs2), 64'(exp.use_rs2));
        end
        if (got.imm !== exp.imm) begin
            note_mismatch("dec_o.imm", 64'(got.imm), 64'(exp.imm));
        end
    endtask

    task automatic check_output();
        if (dec_o.valid) begin
            if (held_valid) begin
                // stalled last cycle, so the same result must still be there
                compare_pc("dec_o.pc", dec_o.pc, held.pc);
                compare_inst("dec_o.inst", dec_o.inst, held.inst);
                compare_order("dec_o.order", dec_o.order, held.order);
                compare_decode(dec_o, held);
            end else begin
                compare_pc("dec_o.pc", dec_o.pc, exp_pc);
                compare_inst("dec_o.inst", dec_o.inst, mem[exp_pc[9:2]]);
                compare_decode(dec_o, decode_model(mem[exp_pc[9:2]]));
                if (!have_last) begin
                    compare_order("dec_o.order", dec_o.order, 64'd0);
                end else if (after_redirect) begin
                    if (dec_o.order <= last_order) begin
                        fail_plain("order did not rise across a redirect");
                    end
                end else begin
                    compare_order("dec_o.order", dec_o.order, last_order + 64'd1);
                end
                last_order     = dec_o.order;
                have_last      = 1'b1;
                after_redirect = 1'b0;
            end
        end else if (held_valid) begin
            fail_plain("decode output lost its valid bit during a stall");
        end
    endtask

    task automatic serve_line();
        line_resp_i = 1'b0;
        if (line_req_o && resp_busy) begin
            fail_plain("second line request while one is outstanding");
        end
        if (resp_busy) begin
            compare_pc("line_addr_o", line_addr_o, resp_addr);
            if (resp_wait == 0) begin
                line_resp_i = 1'b1;
                // poisoned line for a response overtaken by a redirect
                line_data_i = resp_stale ? ~line_at(resp_addr) : line_at(resp_addr);
                resp_busy   = 1'b0;
            end else begin
                resp_wait--;
            end
        end
        if (line_req_o) begin
            if (line_addr_o[4:0] != 5'd0) begin
                fail_plain("line address is not aligned to a line");
            end
            resp_busy  = 1'b1;
            resp_stale = 1'b0;
            resp_addr  = line_addr_o;
            resp_wait  = rand_below(6);
        end
    endtask

    task automatic drive_controls();
        stall_i    = stall_en && (rand_below(4) == 0);
        redirect_i = 1'b0;
        if ((redirect_rate > 0 && rand_below(redirect_rate) == 0) ||
            (redirect_on_req && line_req_o && rand_below(3) == 0)) begin
            redirect_i    = 1'b1;
            redirect_pc_i = {frontend_pkg::RESET_PC[31:10], 8'(rand_below(256)), 2'b00};
            if (resp_busy) begin
                pending_redirects++;
                resp_stale = 1'b1;
            end
        end
    endtask

    task automatic update_model();
        held_valid = dec_o.valid && stall_i && !redirect_i;
        held       = dec_o;
        if (redirect_i) begin
            exp_pc         = redirect_pc_i;
            after_redirect = 1'b1;
        end else if (dec_o.valid && !stall_i) begin
            exp_pc = exp_pc + 32'd4;
            accepted++;
        end
    endtask

    task automatic step();
        @(negedge clk);
        check_output();
        serve_line();
        drive_controls();
        update_model();
    endtask

    task automatic run_test(int num, string name, int insts, logic stall, int rate,
                            logic on_req);
        int start;
        start           = accepted;
        test_errors     = 0;
        stall_en        = stall;
        redirect_rate   = rate;
        redirect_on_req = on_req;
        while (accepted - start < insts) begin
            step();
        end
        $display("test %0d %s: %0d instructions, %0d errors", num, name,
                 accepted - start, test_errors);
    endtask

    initial begin
        seed              = 32'h6151_6064;
        rst               = 1'b1;
        line_resp_i       = 1'b0;
        line_data_i       = '0;
        redirect_i        = 1'b0;
        redirect_pc_i     = '0;
        stall_i           = 1'b0;
        errors            = 0;
        checks            = 0;
        accepted          = 0;
        pending_redirects = 0;
        resp_busy         = 1'b0;
        resp_stale        = 1'b0;
        resp_wait         = 0;
        exp_pc            = frontend_pkg::RESET_PC;
        last_order        = '0;
        have_last         = 1'b0;
        after_redirect    = 1'b0;
        held_valid        = 1'b0;
        fill_memory();

        repeat (4) @(negedge clk);
        if (dec_o.valid !== 1'b0 || line_req_o !== 1'b0) begin
            fail_plain("outputs active while in reset");
        end
        rst = 1'b0;

        run_test(1, "sequential fetch", 300, 1'b0, 0, 1'b0);
        run_test(2, "stall back-pressure", 400, 1'b1, 0, 1'b0);
        run_test(3, "random redirects", 700, 1'b1, 40, 1'b0);
        run_test(4, "redirect during line request", 600, 1'b1, 0, 1'b1);
        if (pending_redirects == 0) begin
            fail_plain("no redirect hit a pending line request");
        end

        $display("summary: %0d instructions, %0d checks, %0d errors, %0d cycles",
                 accepted, checks, errors, cycles);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run went past %0d cycles", CYCLE_LIMIT);
        $display("** FAIL **");
        $finish;
    end

endmodule

/* hw/frontend_top.sv */
`timescale 1ns/10ps

module frontend_top (
    input  logic                    clk,
    input  logic                    rst,

    output logic                    line_req_o,
    output frontend_pkg::addr_t     line_addr_o,
    input  logic                    line_resp_i,
    input  frontend_pkg::line_t     line_data_i,

    input  logic                    redirect_i,
    input  frontend_pkg::addr_t     redirect_pc_i,
    input  logic                    stall_i,

    output frontend_pkg::dec_inst_t dec_o
);

    frontend_pkg::fetch_entry_t fetch_entry;
    frontend_pkg::fetch_entry_t head_entry;
    logic                       push;
    logic                       pop;
    logic                       q_full;
    logic                       q_empty;

    fetch_unit u_fetch (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .line_req_o    (line_req_o),
        .line_addr_o   (line_addr_o),
        .line_resp_i   (line_resp_i),
        .line_data_i   (line_data_i),
        .full_i        (q_full),
        .push_o        (push),
        .entry_o       (fetch_entry)
    );

    // redirect doubles as the queue flush
    inst_queue u_queue (
        .clk     (clk),
        .rst     (rst),
        .flush_i (redirect_i),
        .push_i  (push),
        .entry_i (fetch_entry),
        .full_o  (q_full),
        .pop_i   (pop),
        .head_o  (head_entry),
        .empty_o (q_empty)
    );

    decode_stage u_decode (
        .clk        (clk),
        .rst        (rst),
        .redirect_i (redirect_i),
        .stall_i    (stall_i),
        .empty_i    (q_empty),
        .head_i     (head_entry),
        .pop_o      (pop),
        .dec_o      (dec_o)
    );

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/10ps

module decode_stage (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       redirect_i,
    input  logic                       stall_i,

    input  logic                       empty_i,
    input  frontend_pkg::fetch_entry_t head_i,
    output logic                       pop_o,

    output frontend_pkg::dec_inst_t    dec_o
);

    frontend_pkg::dec_inst_t  dec_next;
    frontend_pkg::inst_word_t inst;
    logic [6:0]               opcode;
    logic                     use_rd;
    logic                     use_rs1;
    logic                     use_rs2;
    logic                     use_imm;

    assign pop_o  = !empty_i && !stall_i;
    assign inst   = head_i.inst;
    assign opcode = inst.r_fmt.opcode;

    always_comb begin
        dec_next          = '0;
        dec_next.op_class = frontend_pkg::op_none;
        use_rd            = 1'b0;
        use_rs1           = 1'b0;
        use_rs2           = 1'b0;
        use_imm           = 1'b0;

        case (opcode)
            frontend_pkg::OPC_LUI,
            frontend_pkg::OPC_AUIPC: begin
                dec_next.op_class = frontend_pkg::op_alu;
                use_rd            = 1'b1;
            end
            frontend_pkg::OPC_OP_IMM: begin
                dec_next.op_class = frontend_pkg::op_alu;
                use_rd            = 1'b1;
                use_rs1           = 1'b1;
                use_imm           = 1'b1;
            end
            frontend_pkg::OPC_OP: begin
                dec_next.op_class = frontend_pkg::op_alu;
                use_rd            = 1'b1;
                use_rs1           = 1'b1;
                use_rs2           = 1'b1;
            end
            frontend_pkg::OPC_BRANCH: begin
                dec_next.op_class = frontend_pkg::op_br;
                use_rs1           = 1'b1;
                use_rs2           = 1'b1;
            end
            frontend_pkg::OPC_JAL: begin
                dec_next.op_class = frontend_pkg::op_br;
                use_rd            = 1'b1;
            end
            frontend_pkg::OPC_JALR: begin
                dec_next.op_class = frontend_pkg::op_br;
                use_rd            = 1'b1;
                use_rs1           = 1'b1;
                use_imm           = 1'b1;
            end
            frontend_pkg::OPC_LOAD: begin
                dec_next.op_class = frontend_pkg::op_mem;
                use_rd            = 1'b1;
                use_rs1           = 1'b1;
                use_imm           = 1'b1;
            end
            frontend_pkg::OPC_STORE: begin
                dec_next.op_class = frontend_pkg::op_mem;
                use_rs1           = 1'b1;
                use_rs2           = 1'b1;
            end
            default: begin
                dec_next.op_class = frontend_pkg::op_none;
            end
        endcase

        dec_next.valid    = pop_o;
        dec_next.order    = head_i.order;
        dec_next.pc       = head_i.pc;
        dec_next.inst     = inst;
        dec_next.use_rs1  = use_rs1;
        dec_next.use_rs2  = use_rs2;
        dec_next.rd_addr  = use_rd ? inst.r_fmt.rd : 5'd0;
        dec_next.rs1_addr = use_rs1 ? inst.r_fmt.rs1 : 5'd0;
        dec_next.rs2_addr = use_rs2 ? inst.r_fmt.rs2 : 5'd0;
        // sign extended i-type immediate
        dec_next.imm      = use_imm ?
            {{(frontend_pkg::XLEN-12){inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12} : '0;
    end

    always_ff @(posedge clk) begin
        if (rst || redirect_i) begin
            dec_o.valid <= 1'b0;
        end else if (!stall_i) begin
            dec_o <= dec_next;
        end
    end

    stall_hold: assert property (@(posedge clk) disable iff (rst)
        (stall_i && !redirect_i && dec_o.valid) |=> $stable(dec_o))
        else $error("decode output changed under stall");

endmodule

/* hw/inst_queue.sv */
`timescale 1ns/10ps

module inst_queue (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush_i,

    input  logic                       push_i,
    input  frontend_pkg::fetch_entry_t entry_i,
    output logic                       full_o,

    input  logic                       pop_i,
    output frontend_pkg::fetch_entry_t head_o,
    output logic                       empty_o
);

    frontend_pkg::fetch_entry_t             slots [frontend_pkg::QUEUE_DEPTH];
    logic [frontend_pkg::QPTR_BITS-1:0]     head_ptr;
    logic [frontend_pkg::QPTR_BITS-1:0]     tail_ptr;
    logic [frontend_pkg::QCNT_BITS-1:0]     count;

    assign full_o  = (count == frontend_pkg::QCNT_BITS'(frontend_pkg::QUEUE_DEPTH));
    assign empty_o = (count == '0);
    assign head_o  = slots[head_ptr];

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (push_i) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (pop_i) begin
                head_ptr <= head_ptr + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_i && !flush_i) begin
            slots[tail_ptr] <= entry_i;
        end
    end

    no_push_full: assert property (@(posedge clk) disable iff (rst)
        push_i |-> !full_o)
        else $error("push into a full queue");

    no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        pop_i |-> !empty_o)
        else $error("pop from an empty queue");

endmodule

/* hw/fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       redirect_i,
    input  frontend_pkg::addr_t        redirect_pc_i,

    output logic                       line_req_o,
    output frontend_pkg::addr_t        line_addr_o,
    input  logic                       line_resp_i,
    input  frontend_pkg::line_t        line_data_i,

    input  logic                       full_i,
    output logic                       push_o,
    output frontend_pkg::fetch_entry_t entry_o
);

    frontend_pkg::addr_t                                pc;
    logic [frontend_pkg::ORDER_BITS-1:0]                order;
    frontend_pkg::line_t                                buf_line;
    logic [frontend_pkg::XLEN-1:frontend_pkg::LINE_OFF_BITS] buf_tag;
    logic                                               buf_valid;
    logic                                               pending;
    logic                                               stale;
    logic                                               hit;
    logic [frontend_pkg::WORD_SEL_BITS-1:0]             word_sel;

    assign hit = buf_valid &&
                 (pc[frontend_pkg::XLEN-1:frontend_pkg::LINE_OFF_BITS] == buf_tag);
    assign word_sel = pc[frontend_pkg::LINE_OFF_BITS-1:2];

    // no push on a redirect edge since the queue flushes there
    assign push_o = hit && !full_i && !redirect_i;

    assign entry_o.order    = order;
    assign entry_o.pc       = pc;
    assign entry_o.inst.raw = buf_line[word_sel];

    always_ff @(posedge clk) begin
        if (rst) begin
            pc    <= frontend_pkg::RESET_PC;
            order <= '0;
        end else if (redirect_i) begin
            pc <= redirect_pc_i;
        end else if (push_o) begin
            pc    <= pc + 32'd4;
            order <= order + 1'b1;
        end
    end

    // one outstanding line request at a time
    always_ff @(posedge clk) begin
        if (rst) begin
            line_req_o <= 1'b0;
            pending    <= 1'b0;
            stale      <= 1'b0;
        end else begin
            line_req_o <= 1'b0;
            if (line_resp_i) begin
                pending <= 1'b0;
                stale   <= 1'b0;
            end else if (!pending && !hit && !redirect_i) begin
                line_req_o <= 1'b1;
                pending    <= 1'b1;
            end else if (pending && redirect_i) begin
                // drop the old path response when it shows up
                stale <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            buf_valid <= 1'b0;
        end else if (line_resp_i && !stale) begin
            buf_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!pending && !hit) begin
            line_addr_o <= {pc[frontend_pkg::XLEN-1:frontend_pkg::LINE_OFF_BITS],
                            {frontend_pkg::LINE_OFF_BITS{1'b0}}};
        end
        if (line_resp_i && !stale) begin
            buf_line <= line_data_i;
            buf_tag  <= line_addr_o[frontend_pkg::XLEN-1:frontend_pkg::LINE_OFF_BITS];
        end
    end

    // a new request only after the previous response came back
    req_while_pending: assert property (@(posedge clk) disable iff (rst)
        (pending && !line_resp_i) |=> !line_req_o)
        else $error("line request issued while one is pending");

endmodule

/* hw/frontend_pkg.sv */
package frontend_pkg;

    localparam int XLEN        = 32;
    localparam int LINE_BITS   = 256;
    localparam int LINE_WORDS  = 8;
    localparam int ORDER_BITS  = 64;
    localparam int QUEUE_DEPTH = 8;

    localparam logic [XLEN-1:0] RESET_PC = 32'haaaaa000;

    // derived widths
    localparam int LINE_OFF_BITS = $clog2(LINE_BITS / 8);
    localparam int WORD_SEL_BITS = $clog2(LINE_WORDS);
    localparam int QPTR_BITS     = $clog2(QUEUE_DEPTH);
    localparam int QCNT_BITS     = $clog2(QUEUE_DEPTH + 1);

    // rv32i major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    typedef logic [XLEN-1:0] addr_t;

    // word 0 sits in the low bits
    typedef logic [LINE_WORDS-1:0][XLEN-1:0] line_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t          r_fmt;
        i_fmt_t          i_fmt;
        logic [XLEN-1:0] raw;
    } inst_word_t;

    typedef enum logic [1:0] {
        op_alu,
        op_br,
        op_mem,
        op_none
    } op_class_t;

    typedef struct packed {
        logic [ORDER_BITS-1:0] order;
        addr_t                 pc;
        inst_word_t            inst;
    } fetch_entry_t;

    typedef struct packed {
        logic                  valid;
        logic [ORDER_BITS-1:0] order;
        addr_t                 pc;
        inst_word_t            inst;
        op_class_t             op_class;
        logic [4:0]            rd_addr;
        logic [4:0]            rs1_addr;
        logic [4:0]            rs2_addr;
        logic                  use_rs1;
        logic                  use_rs2;
        logic [XLEN-1:0]       imm;
    } dec_inst_t;

endpackage
